// File: mem_sys.f
hw/cache_pkg.sv
hw/mem_pkg.sv
hw/req_latch.sv
hw/cache_way.sv
hw/cache_ctrl.sv
hw/main_mem.sv
hw/mem_sys.sv
dv/mem_sys_properties.sv
dv/mem_sys_tb.sv

// File: run_verilator.sh
#!/usr/bin/env bash
# Build and run the mem_sys testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    --top-module mem_sys_tb \
    --Mdir obj_dir \
    -o mem_sys_tb \
    -f mem_sys.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/mem_sys_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit "$sim_status"
fi

echo "Simulation ended with status 0"
exit 0

// File: dv/mem_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb;

    localparam int num_directed = 14;
    localparam int num_random = 400;
    // Worst case is a dirty miss plus one idle cycle
    localparam int cycle_limit = 12 * (num_directed + num_random) + 100;

    logic clk;
    logic rst;
    logic req;
    logic rd;
    logic wr;
    logic [15:0] addr;
    logic [cache_pkg::word_w-1:0] data_in;
    logic [cache_pkg::word_w-1:0] data_out;
    logic done;
    logic cache_hit;
    logic err;
    logic stall;

    // Reference model
    logic [cache_pkg::word_w-1:0] model_mem [mem_pkg::mem_words];
    logic [cache_pkg::tag_w-1:0] model_tag [cache_pkg::num_sets][2];
    logic model_valid [cache_pkg::num_sets][2];
    logic model_dirty [cache_pkg::num_sets][2];
    logic model_victim;

    int cycle_count = 0;
    logic [31:0] rnd;

    mem_sys dut_i (
        .clk(clk),
        .rst(rst),
        .req(req),
        .rd(rd),
        .wr(wr),
        .addr(addr),
        .data_in(data_in),
        .data_out(data_out),
        .done(done),
        .cache_hit(cache_hit),
        .err(err),
        .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count <= cycle_limit) else begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [7:0] index,
                                              input logic [1:0] word);
        return {tag, index, word, 1'b0};
    endfunction

    // Small pools so that sets fill, evict and write back
    function automatic logic [4:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0: return 5'h03;
            2'd1: return 5'h0a;
            2'd2: return 5'h11;
            default: return 5'h1e;
        endcase
    endfunction

    function automatic logic [7:0] pick_index(input logic [1:0] sel);
        case (sel)
            2'd0: return 8'h10;
            2'd1: return 8'h47;
            2'd2: return 8'h9c;
            default: return 8'hf3;
        endcase
    endfunction

    task automatic reset_model();
        for (int i = 0; i < mem_pkg::mem_words; i++) begin
            model_mem[i] = '0;
        end
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            for (int w = 0; w < 2; w++) begin
                model_tag[s][w] = '0;
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        model_victim = 1'b0;
    endtask

    // Hit/miss, latency and data for one aligned access, then update the model
    task automatic model_access(input logic [15:0] a, input logic is_wr,
                                input logic [15:0] wdata, output logic exp_hit,
                                output int exp_cycles, output logic [15:0] exp_data);
        logic [4:0] t;
        logic [7:0] s;
        logic hit0;
        logic hit1;
        logic way;
        t = a[15:11];
        s = a[10:3];
        hit0 = model_valid[s][0] && model_tag[s][0] == t;
        hit1 = model_valid[s][1] && model_tag[s][1] == t;
        if (hit0 || hit1) begin
            exp_hit = 1'b1;
            exp_cycles = 1;
            way = hit1;
            if (is_wr) begin
                model_dirty[s][way] = 1'b1;
            end
        end else begin
            exp_hit = 1'b0;
            if (model_valid[s][0] && model_valid[s][1]) begin
                way = model_victim;
            end else if (model_valid[s][0]) begin
                way = 1'b1;
            end else begin
                way = 1'b0;
            end
            exp_cycles = (model_valid[s][way] && model_dirty[s][way]) ? 11 : 7;
            model_tag[s][way] = t;
            model_valid[s][way] = 1'b1;
            model_dirty[s][way] = is_wr;
            model_victim = !model_victim;
        end
        if (is_wr) begin
            model_mem[a[15:1]] = wdata;
        end
        exp_data = model_mem[a[15:1]];
    endtask

    task automatic run_access(input logic [15:0] a, input logic is_wr,
                              input logic [15:0] wdata);
        logic exp_hit;
        logic [15:0] exp_data;
        int exp_cycles;
        int n;
        if (a[0]) begin
            // Misaligned, nothing in the model changes
            exp_hit = 1'b0;
            exp_cycles = 1;
            exp_data = '0;
        end else begin
            model_access(a, is_wr, wdata, exp_hit, exp_cycles, exp_data);
        end
        @(negedge clk);
        check_bit("done", 1'b0, done);
        check_bit("stall", 1'b0, stall);
        req = 1'b1;
        rd = !is_wr;
        wr = is_wr;
        addr = a;
        data_in = wdata;
        n = 0;
        do begin
            @(negedge clk);
            req = 1'b0;
            n++;
            check_bit("stall", 1'b1, stall);
            assert (done || n < exp_cycles) else begin
                $display("done not seen within %0d cycles for address %h", exp_cycles, a);
                abort_run();
            end
        end while (!done);
        check_count("done latency", exp_cycles, n);
        check_bit("err", a[0], err);
        check_bit("cache_hit", exp_hit, cache_hit);
        if (!a[0] && !is_wr) begin
            check_word("data_out", exp_data, data_out);
        end
    endtask

    initial begin
        logic [15:0] a;
        rnd = $urandom(32'haf858b30);
        rst = 1'b1;
        req = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        data_in = '0;
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit("stall", 1'b0, stall);
        check_bit("done", 1'b0, done);
        check_bit("err", 1'b0, err);
        check_bit("cache_hit", 1'b0, cache_hit);

        // First touch of a set misses
        run_access(make_addr(5'h00, 8'h00, 2'd0), 1'b0, 16'h0000);
        // Write then read back the word and its neighbors
        run_access(make_addr(5'h05, 8'h10, 2'd1), 1'b1, 16'h1234);
        run_access(make_addr(5'h05, 8'h10, 2'd1), 1'b0, 16'h0000);
        run_access(make_addr(5'h05, 8'h10, 2'd2), 1'b0, 16'h0000);
        run_access(make_addr(5'h05, 8'h10, 2'd0), 1'b0, 16'h0000);
        // Second way, then two more tags push both dirty lines out
        run_access(make_addr(5'h09, 8'h10, 2'd3), 1'b1, 16'hbeef);
        run_access(make_addr(5'h0c, 8'h10, 2'd0), 1'b0, 16'h0000);
        run_access(make_addr(5'h0e, 8'h10, 2'd0), 1'b0, 16'h0000);
        run_access(make_addr(5'h05, 8'h10, 2'd1), 1'b0, 16'h0000);
        run_access(make_addr(5'h09, 8'h10, 2'd3), 1'b0, 16'h0000);
        // Odd addresses must not disturb anything
        run_access(make_addr(5'h05, 8'h10, 2'd1) | 16'h0001, 1'b1, 16'hdead);
        run_access(make_addr(5'h09, 8'h10, 2'd3) | 16'h0001, 1'b0, 16'h0000);
        run_access(make_addr(5'h05, 8'h10, 2'd1), 1'b0, 16'h0000);
        run_access(make_addr(5'h09, 8'h10, 2'd3), 1'b0, 16'h0000);

        for (int i = 0; i < num_random; i++) begin
            rnd = $urandom;
            a = make_addr(pick_tag(rnd[1:0]), pick_index(rnd[3:2]), rnd[5:4]);
            // Roughly one in sixteen misaligned
            if (rnd[11:8] == 4'd0) begin
                a[0] = 1'b1;
            end
            run_access(a, rnd[6], rnd[31:16]);
        end

        @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/mem_sys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_properties (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic err,
    input logic stall,
    input logic mem_rd,
    input logic mem_wr
);

    // Completion only for a held request
    done_needs_busy: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !(done || err))
        else $error("done or err raised while no request was held");

    // Memory port carries one command at a time
    mem_cmd_onehot: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd && mem_wr))
        else $error("memory read and write issued in the same cycle");

    // No request held means the controller is back in idle
    idle_no_stall: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !stall)
        else $error("stall high while the controller was idle");

endmodule

bind cache_ctrl mem_sys_properties props_i (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .done(done),
    .err(err),
    .stall(stall),
    .mem_rd(mem_rd),
    .mem_wr(mem_wr)
);

`default_nettype wire

// File: hw/mem_sys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic rd,
    input  logic wr,
    input  logic [$bits(cache_pkg::cache_addr_t)-1:0] addr,
    input  logic [cache_pkg::word_w-1:0] data_in,
    output logic [cache_pkg::word_w-1:0] data_out,
    output logic done,
    output logic cache_hit,
    output logic err,
    output logic stall
);

    logic busy;
    logic held_rd;
    logic held_wr;
    cache_pkg::cache_addr_t held_addr;
    logic [cache_pkg::word_w-1:0] held_data;
    logic misaligned;
    logic clear;

    logic way0_en;
    logic way1_en;
    logic [cache_pkg::index_w-1:0] index;
    logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel;
    logic [cache_pkg::tag_w-1:0] tag;
    logic [cache_pkg::word_w-1:0] way_data_in;
    logic comp;
    logic write;
    logic valid_in;

    logic way0_hit;
    logic way0_valid;
    logic way0_dirty;
    logic [cache_pkg::tag_w-1:0] way0_tag;
    logic [cache_pkg::word_w-1:0] way0_data;
    logic way1_hit;
    logic way1_valid;
    logic way1_dirty;
    logic [cache_pkg::tag_w-1:0] way1_tag;
    logic [cache_pkg::word_w-1:0] way1_data;

    logic mem_rd;
    logic mem_wr;
    logic [$bits(cache_pkg::cache_addr_t)-1:0] mem_addr;
    logic [cache_pkg::word_w-1:0] mem_data_in;
    logic [cache_pkg::word_w-1:0] mem_data_out;

    req_latch u_latch (
        .clk(clk), .rst(rst), .req(req), .rd(rd), .wr(wr),
        .addr(addr), .data_in(data_in), .clear(clear),
        .busy(busy), .held_rd(held_rd), .held_wr(held_wr),
        .held_addr(held_addr), .held_data(held_data), .misaligned(misaligned)
    );

    cache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .busy(busy), .held_rd(held_rd), .held_wr(held_wr),
        .held_addr(held_addr), .held_data(held_data), .misaligned(misaligned),
        .way0_hit(way0_hit), .way0_valid(way0_valid), .way0_dirty(way0_dirty),
        .way0_tag(way0_tag), .way0_data(way0_data),
        .way1_hit(way1_hit), .way1_valid(way1_valid), .way1_dirty(way1_dirty),
        .way1_tag(way1_tag), .way1_data(way1_data),
        .mem_data_out(mem_data_out),
        .way0_en(way0_en), .way1_en(way1_en), .index(index), .word_sel(word_sel),
        .tag(tag), .way_data_in(way_data_in), .comp(comp), .write(write),
        .valid_in(valid_in), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_data_in(mem_data_in), .data_out(data_out), .done(done),
        .cache_hit(cache_hit), .err(err), .stall(stall), .clear(clear)
    );

    cache_way u_way0 (
        .clk(clk), .rst(rst), .enable(way0_en), .index(index), .word_sel(word_sel),
        .tag_in(tag), .data_in(way_data_in), .comp(comp), .write(write),
        .valid_in(valid_in), .hit(way0_hit), .valid(way0_valid), .dirty(way0_dirty),
        .tag_out(way0_tag), .data_out(way0_data)
    );

    cache_way u_way1 (
        .clk(clk), .rst(rst), .enable(way1_en), .index(index), .word_sel(word_sel),
        .tag_in(tag), .data_in(way_data_in), .comp(comp), .write(write),
        .valid_in(valid_in), .hit(way1_hit), .valid(way1_valid), .dirty(way1_dirty),
        .tag_out(way1_tag), .data_out(way1_data)
    );

    main_mem u_mem (
        .clk(clk), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
        .data_in(mem_data_in), .data_out(mem_data_out)
    );

endmodule

`default_nettype wire

// File: hw/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

module main_mem (
    input  logic clk,
    input  logic rd,
    input  logic wr,
    input  logic [$clog2(mem_pkg::mem_words):0] addr,
    input  logic [cache_pkg::word_w-1:0] data_in,
    output logic [cache_pkg::word_w-1:0] data_out
);

    logic [cache_pkg::word_w-1:0] mem [mem_pkg::mem_words];
    logic [cache_pkg::word_w-1:0] pipe_q [mem_pkg::mem_rd_latency];
    logic [$clog2(mem_pkg::mem_words)-1:0] word_addr;

    // Byte address to word index
    assign word_addr = addr[$clog2(mem_pkg::mem_words):1];

    initial begin
        for (int i = 0; i < mem_pkg::mem_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr) begin
            mem[word_addr] <= data_in;
        end
    end

    // One new read per cycle, each shifted through the latency stages
    always_ff @(posedge clk) begin
        pipe_q[0] <= rd ? mem[word_addr] : '0;
        for (int i = 1; i < mem_pkg::mem_rd_latency; i++) begin
            pipe_q[i] <= pipe_q[i-1];
        end
    end

    assign data_out = pipe_q[mem_pkg::mem_rd_latency-1];

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic busy,
    input  logic held_rd,
    input  logic held_wr,
    input  cache_pkg::cache_addr_t held_addr,
    input  logic [cache_pkg::word_w-1:0] held_data,
    input  logic misaligned,
    input  logic way0_hit,
    input  logic way0_valid,
    input  logic way0_dirty,
    input  logic [cache_pkg::tag_w-1:0] way0_tag,
    input  logic [cache_pkg::word_w-1:0] way0_data,
    input  logic way1_hit,
    input  logic way1_valid,
    input  logic way1_dirty,
    input  logic [cache_pkg::tag_w-1:0] way1_tag,
    input  logic [cache_pkg::word_w-1:0] way1_data,
    input  logic [cache_pkg::word_w-1:0] mem_data_out,
    output logic way0_en,
    output logic way1_en,
    output logic [cache_pkg::index_w-1:0] index,
    output logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel,
    output logic [cache_pkg::tag_w-1:0] tag,
    output logic [cache_pkg::word_w-1:0] way_data_in,
    output logic comp,
    output logic write,
    output logic valid_in,
    output logic mem_rd,
    output logic mem_wr,
    output logic [$bits(cache_pkg::cache_addr_t)-1:0] mem_addr,
    output logic [cache_pkg::word_w-1:0] mem_data_in,
    output logic [cache_pkg::word_w-1:0] data_out,
    output logic done,
    output logic cache_hit,
    output logic err,
    output logic stall,
    output logic clear
);

    localparam int sel_w = $clog2(cache_pkg::words_per_line);

    localparam logic [3:0] ST_IDLE = 4'd0;
    localparam logic [3:0] ST_COMPARE = 4'd1;
    localparam logic [3:0] ST_WB0 = 4'd2;
    localparam logic [3:0] ST_WB1 = 4'd3;
    localparam logic [3:0] ST_WB2 = 4'd4;
    localparam logic [3:0] ST_WB3 = 4'd5;
    localparam logic [3:0] ST_FILL0 = 4'd6;
    localparam logic [3:0] ST_FILL1 = 4'd7;
    localparam logic [3:0] ST_FILL2 = 4'd8;
    localparam logic [3:0] ST_FILL3 = 4'd9;
    localparam logic [3:0] ST_FILL4 = 4'd10;
    localparam logic [3:0] ST_FILL5 = 4'd11;

    logic [3:0] state_q;
    logic [3:0] state;
    logic [3:0] state_d;
    logic [3:0] wb_step;
    logic [3:0] rd_step;
    logic [3:0] in_step;
    logic in_cmp;
    logic installing;
    logic any_hit;
    logic miss_way;
    logic sel_way;
    logic way_q;
    logic victim_q;
    logic sel_valid;
    logic sel_dirty;
    logic [cache_pkg::tag_w-1:0] sel_tag;
    logic [cache_pkg::word_w-1:0] sel_data;
    logic [cache_pkg::word_w-1:0] temp_q;
    logic [sel_w-1:0] req_word;
    cache_pkg::cache_addr_t mem_a;

    // Compare is idle with a held request, so a hit finishes one cycle after the strobe
    assign state = (state_q == ST_IDLE && busy) ? ST_COMPARE : state_q;
    assign in_cmp = state == ST_COMPARE;
    assign installing = state >= ST_FILL2 && state <= ST_FILL5;

    assign wb_step = state - ST_WB0;
    assign rd_step = state - ST_FILL0;
    assign in_step = state - ST_FILL2;
    assign req_word = held_addr.fields.offset[cache_pkg::offset_w-1 -: sel_w];

    assign any_hit = way0_hit || way1_hit;

    // Replacement: an invalid way first, else the victim bit
    always_comb begin
        if (way0_valid && way1_valid) begin
            miss_way = victim_q;
        end else if (way0_valid) begin
            miss_way = 1'b1;
        end else begin
            miss_way = 1'b0;
        end
    end

    assign sel_way = in_cmp ? (any_hit ? way1_hit : miss_way) : way_q;
    assign sel_valid = sel_way ? way1_valid : way0_valid;
    assign sel_dirty = sel_way ? way1_dirty : way0_dirty;
    assign sel_tag = sel_way ? way1_tag : way0_tag;
    assign sel_data = sel_way ? way1_data : way0_data;

    assign way0_en = in_cmp ? !misaligned : (state != ST_IDLE) && !way_q;
    assign way1_en = in_cmp ? !misaligned : (state != ST_IDLE) && way_q;
    // Last install of a write miss goes through compare so the line ends up dirty
    assign comp = in_cmp || (state == ST_FILL5 && held_wr);
    assign stall = state != ST_IDLE;
    assign index = held_addr.fields.index;
    assign mem_addr = mem_a.word;

    always_comb begin
        state_d = ST_IDLE;
        word_sel = req_word;
        tag = held_addr.fields.tag;
        way_data_in = held_data;
        write = 1'b0;
        valid_in = 1'b0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        mem_a = held_addr;
        mem_data_in = sel_data;
        data_out = sel_data;
        done = 1'b0;
        cache_hit = 1'b0;
        err = 1'b0;
        clear = 1'b0;

        case (state)
            ST_COMPARE: begin
                write = held_wr && !misaligned;
                if (misaligned) begin
                    err = 1'b1;
                    done = 1'b1;
                    clear = 1'b1;
                end else if (any_hit) begin
                    done = 1'b1;
                    cache_hit = 1'b1;
                    clear = 1'b1;
                end else if (sel_valid && sel_dirty) begin
                    state_d = ST_WB0;
                end else begin
                    state_d = ST_FILL0;
                end
            end
            ST_WB0, ST_WB1, ST_WB2, ST_WB3: begin
                // Victim word out under the victim's own tag
                word_sel = wb_step[sel_w-1:0];
                mem_wr = 1'b1;
                mem_a.fields.tag = sel_tag;
                mem_a.fields.offset = {wb_step[sel_w-1:0],
                                       {(cache_pkg::offset_w - sel_w){1'b0}}};
                state_d = state + 4'd1;
            end
            ST_FILL0, ST_FILL1, ST_FILL2, ST_FILL3, ST_FILL4: begin
                state_d = state + 4'd1;
            end
            ST_FILL5: begin
                done = 1'b1;
                clear = 1'b1;
                data_out = (held_rd && req_word == in_step[sel_w-1:0]) ? mem_data_out : temp_q;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase

        if (state >= ST_FILL0 && state <= ST_FILL3) begin
            mem_rd = 1'b1;
            mem_a.fields.offset = {rd_step[sel_w-1:0], {(cache_pkg::offset_w - sel_w){1'b0}}};
        end

        // Read data arrives two states after its read, merged with the write word
        if (installing) begin
            write = 1'b1;
            valid_in = 1'b1;
            word_sel = in_step[sel_w-1:0];
            if (held_wr && in_step[sel_w-1:0] == req_word) begin
                way_data_in = held_data;
            end else begin
                way_data_in = mem_data_out;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            way_q <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (in_cmp) begin
                way_q <= sel_way;
            end
            if (state == ST_FILL5) begin
                victim_q <= ~victim_q;
            end
        end
    end

    // Requested word kept until done
    always_ff @(posedge clk) begin
        if (installing && in_step[sel_w-1:0] == req_word) begin
            temp_q <= mem_data_out;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic [$clog2(cache_pkg::words_per_line)-1:0] word_sel,
    input  logic [cache_pkg::tag_w-1:0] tag_in,
    input  logic [cache_pkg::word_w-1:0] data_in,
    input  logic comp,
    input  logic write,
    input  logic valid_in,
    output logic hit,
    output logic valid,
    output logic dirty,
    output logic [cache_pkg::tag_w-1:0] tag_out,
    output logic [cache_pkg::word_w-1:0] data_out
);

    logic [cache_pkg::tag_w-1:0] tag_q [cache_pkg::num_sets];
    logic [cache_pkg::num_sets-1:0] valid_q;
    logic [cache_pkg::num_sets-1:0] dirty_q;
    logic [cache_pkg::word_w-1:0] data_q [cache_pkg::num_sets][cache_pkg::words_per_line];

    logic tag_match;
    logic install;
    logic wr_en;

    assign tag_match = tag_q[index] == tag_in;
    assign hit = enable && comp && valid_q[index] && tag_match;

    // Install writes always land, compare writes only on a hit
    assign install = enable && write && !comp;
    assign wr_en = install || (write && hit);

    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign tag_out = tag_q[index];
    assign data_out = data_q[index][word_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (install) begin
            valid_q[index] <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q[index][word_sel] <= data_in;
            // Set on a compare write, cleared by an install
            dirty_q[index] <= comp;
            if (!comp) begin
                tag_q[index] <= tag_in;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/req_latch.sv
`timescale 1ns/1ps
`default_nettype none

module req_latch (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic rd,
    input  logic wr,
    input  cache_pkg::cache_addr_t addr,
    input  logic [cache_pkg::word_w-1:0] data_in,
    input  logic clear,
    output logic busy,
    output logic held_rd,
    output logic held_wr,
    output cache_pkg::cache_addr_t held_addr,
    output logic [cache_pkg::word_w-1:0] held_data,
    output logic misaligned
);

    logic take;

    // Strobes seen while a request is pending are dropped
    assign take = req && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            held_rd <= 1'b0;
            held_wr <= 1'b0;
            misaligned <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            held_rd <= rd;
            held_wr <= wr;
            // Odd byte address
            misaligned <= addr.fields.offset[0];
        end else if (clear) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_addr <= addr;
            held_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Depth in 16-bit words, addressed by byte address bits 15 to 1
    localparam int mem_words = 32768;

    // Cycles from a read strobe to valid data
    localparam int mem_rd_latency = 2;

endpackage

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Two-way set-associative geometry
    localparam int tag_w = 5;
    localparam int index_w = 8;
    localparam int offset_w = 3;

    localparam int num_sets = 256;
    localparam int words_per_line = 4;
    localparam int word_w = 16;

    // Byte address, seen flat by memory and split by the cache
    typedef union packed {
        logic [tag_w+index_w+offset_w-1:0] word;
        struct packed {
            logic [tag_w-1:0] tag;
            logic [index_w-1:0] index;
            logic [offset_w-1:0] offset;
        } fields;
    } cache_addr_t;

endpackage

`default_nettype wire
